//--- include/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------

// register and data word
`define CPU_DATA_W      16

// program counter, also the data byte address
`define CPU_PC_W        12

`define CPU_ADDR_W      32    // memory bus address

// register index, sixteen registers
`define CPU_REG_IDX_W   4

// ----------------------------------------------------------------------
// memory map
// ----------------------------------------------------------------------
`define CPU_MEM_BASE    32'h1000    // added to pc and data addresses

`endif

//--- verilog/cpu_pkg.sv
`default_nettype none
`include "cpu_defines.svh"

package cpu_pkg;

    // controller sequence, one instruction at a time
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        MEM_LOAD,
        MEM_STORE,
        WRITE_BACK
    } cpu_state_e;

    // 110 and 111 left free, treated as no-ops
    typedef enum logic [2:0] {
        OP_ADDSUB = 3'b000,   // func selects sub
        OP_SLTMUL = 3'b001,   // func selects mul
        OP_LOAD   = 3'b010,
        OP_STORE  = 3'b011,
        OP_BEQ    = 3'b100,
        OP_JUMP   = 3'b101
    } opcode_e;

    // immediate is {rd, func}, jump target the low 13 bits
    typedef struct packed {
        opcode_e                   op;
        logic [`CPU_REG_IDX_W-1:0] rs;
        logic [`CPU_REG_IDX_W-1:0] rt;
        logic [`CPU_REG_IDX_W-1:0] rd;
        logic                      func;
    } inst_t;

    typedef struct packed {
        logic signed [`CPU_DATA_W-1:0] rs_data;
        logic signed [`CPU_DATA_W-1:0] rt_data;
    } operands_t;

    // ------------------------------------------------------------------
    // single beat bus channels
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                   arvalid;
        logic [`CPU_ADDR_W-1:0] araddr;
        logic                   rready;
    } axi_rd_m_t;

    typedef struct packed {
        logic                   arready;
        logic                   rvalid;
        logic [`CPU_DATA_W-1:0] rdata;
    } axi_rd_s_t;

    typedef struct packed {
        logic                   awvalid;
        logic [`CPU_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [`CPU_DATA_W-1:0] wdata;
        logic                   bready;
    } axi_wr_m_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } axi_wr_s_t;

endpackage

`default_nettype wire

//--- verilog/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  inst_t inst,
    input  logic  inst_valid,
    input  logic  load_valid,
    input  logic  store_done,
    output logic  fetch_start,
    output logic  decode_en,
    output logic  exec_en,
    output logic  wb_en,
    output logic  load_start,
    output logic  store_start,
    output logic  io_stall
);

    cpu_state_e state;
    cpu_state_e next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------------
    // stage sequencing
    // ------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE:       next_state = FETCH;
            FETCH:      if (inst_valid) next_state = DECODE;
            DECODE:     next_state = EXECUTE;
            EXECUTE: begin
                case (inst.op)
                    OP_ADDSUB, OP_SLTMUL: next_state = WRITE_BACK;
                    OP_LOAD:              next_state = MEM_LOAD;
                    OP_STORE:             next_state = MEM_STORE;
                    default:              next_state = FETCH;  // beq, jump, no-ops
                endcase
            end
            MEM_LOAD:   if (load_valid) next_state = FETCH;
            MEM_STORE:  if (store_done) next_state = FETCH;
            WRITE_BACK: next_state = FETCH;
            default:    next_state = IDLE;
        endcase
    end

    // one cycle enables follow the state directly
    assign decode_en = (state == DECODE);
    assign exec_en   = (state == EXECUTE);
    assign wb_en     = (state == WRITE_BACK);

    // start pulses land in the first cycle of the new state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_start <= 1'b0;
            load_start  <= 1'b0;
            store_start <= 1'b0;
            io_stall    <= 1'b1;
        end else begin
            fetch_start <= (next_state == FETCH) && (state != FETCH);
            load_start  <= (next_state == MEM_LOAD) && (state != MEM_LOAD);
            store_start <= (next_state == MEM_STORE) && (state != MEM_STORE);
            // low for one cycle per retired instruction
            io_stall    <= !((next_state == FETCH) && (state != FETCH) && (state != IDLE));
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module fetch_unit
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      fetch_start,
    input  logic      exec_en,
    input  logic      branch_taken,
    output axi_rd_m_t imem_m,
    input  axi_rd_s_t imem_s,
    output inst_t     inst,
    output logic      inst_valid
);

    logic [`CPU_PC_W-1:0]   pc;
    logic [`CPU_PC_W-1:0]   br_offset;
    logic [`CPU_ADDR_W-1:0] ar_addr;
    logic                   ar_valid;
    logic                   r_ready;

    // signed immediate times two
    assign br_offset = {{(`CPU_PC_W-6){inst.rd[3]}}, inst.rd, inst.func, 1'b0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (exec_en) begin
            if (inst.op == OP_JUMP) begin
                pc <= inst[`CPU_PC_W-1:0];   // target truncated to pc width
            end else if (inst.op == OP_BEQ && branch_taken) begin
                pc <= pc + `CPU_PC_W'd2 + br_offset;
            end else begin
                pc <= pc + `CPU_PC_W'd2;
            end
        end
    end

    // ------------------------------------------------------------------
    // instruction read, address beat then data beat
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid   <= 1'b0;
            r_ready    <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            if (fetch_start) begin
                ar_valid <= 1'b1;
            end else if (ar_valid && imem_s.arready) begin
                ar_valid <= 1'b0;
                r_ready  <= 1'b1;
            end else if (r_ready && imem_s.rvalid) begin
                r_ready    <= 1'b0;
                inst_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) begin
            ar_addr <= `CPU_MEM_BASE + {{(`CPU_ADDR_W-`CPU_PC_W){1'b0}}, pc};
        end
        if (r_ready && imem_s.rvalid) begin
            inst <= inst_t'(imem_s.rdata);
        end
    end

    assign imem_m = '{arvalid: ar_valid, araddr: ar_addr, rready: r_ready};

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module reg_file
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  inst_t                  inst,
    input  logic                   decode_en,
    input  logic                   wb_en,
    input  logic                   load_valid,
    input  logic [`CPU_DATA_W-1:0] alu_result,
    input  logic [`CPU_DATA_W-1:0] load_data,
    output operands_t              operands
);

    localparam int NUM_REGS = 1 << `CPU_REG_IDX_W;

    logic signed [`CPU_DATA_W-1:0] regs [NUM_REGS];

    // ------------------------------------------------------------------
    // write ports, never active in the same cycle
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[inst.rd] <= alu_result;      // arithmetic result to rd
        end else if (load_valid) begin
            regs[inst.rt] <= load_data;       // load result to rt
        end
    end

    // operand latch for execute and store data
    always_ff @(posedge clk) begin
        if (decode_en) begin
            operands.rs_data <= regs[inst.rs];
            operands.rt_data <= regs[inst.rt];
        end
    end

endmodule

`default_nettype wire

//--- verilog/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module execute_unit
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   exec_en,
    input  inst_t                  inst,
    input  operands_t              operands,
    output logic [`CPU_DATA_W-1:0] alu_result,
    output logic [`CPU_PC_W-1:0]   data_addr,
    output logic                   branch_taken
);

    logic signed [2*`CPU_DATA_W-1:0] product;
    logic [`CPU_DATA_W-1:0]          alu_next;
    logic [`CPU_DATA_W-1:0]          imm_ext;
    logic [`CPU_DATA_W-1:0]          addr_sum;
    logic                            less_than;

    assign product   = operands.rs_data * operands.rt_data;
    assign less_than = operands.rs_data < operands.rt_data;   // signed compare

    // ------------------------------------------------------------------
    // result select by opcode and func
    // ------------------------------------------------------------------
    always_comb begin
        if (inst.op == OP_SLTMUL) begin
            if (inst.func) begin
                alu_next = product[`CPU_DATA_W-1:0];    // low half only
            end else begin
                alu_next = {{(`CPU_DATA_W-1){1'b0}}, less_than};
            end
        end else if (inst.func) begin
            alu_next = operands.rs_data - operands.rt_data;
        end else begin
            alu_next = operands.rs_data + operands.rt_data;
        end
    end

    // word address rs + imm, shifted to bytes
    assign imm_ext  = {{(`CPU_DATA_W-5){inst.rd[3]}}, inst.rd, inst.func};
    assign addr_sum = operands.rs_data + imm_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_result <= '0;
            data_addr  <= '0;
        end else if (exec_en) begin
            alu_result <= alu_next;
            data_addr  <= {addr_sum[`CPU_PC_W-2:0], 1'b0};
        end
    end

    assign branch_taken = (operands.rs_data == operands.rt_data);

endmodule

`default_nettype wire

//--- verilog/mem_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module mem_unit
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_start,
    input  logic                   store_start,
    input  logic [`CPU_PC_W-1:0]   data_addr,
    input  operands_t              operands,
    output axi_rd_m_t              dmem_rd_m,
    input  axi_rd_s_t              dmem_rd_s,
    output axi_wr_m_t              dmem_wr_m,
    input  axi_wr_s_t              dmem_wr_s,
    output logic [`CPU_DATA_W-1:0] load_data,
    output logic                   load_valid,
    output logic                   store_done
);

    typedef enum logic [1:0] {LD_IDLE, LD_ADDR, LD_DATA} load_state_e;
    typedef enum logic [1:0] {ST_IDLE, ST_AW, ST_W, ST_B} store_state_e;

    load_state_e            ld_state;
    store_state_e           st_state;
    logic [`CPU_ADDR_W-1:0] mem_addr;     // shared, load and store never overlap
    logic [`CPU_DATA_W-1:0] st_data;

    // ------------------------------------------------------------------
    // load read
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_state   <= LD_IDLE;
            load_valid <= 1'b0;
        end else begin
            load_valid <= 1'b0;
            case (ld_state)
                LD_IDLE: if (load_start) ld_state <= LD_ADDR;
                LD_ADDR: if (dmem_rd_s.arready) ld_state <= LD_DATA;
                LD_DATA: begin
                    if (dmem_rd_s.rvalid) begin
                        ld_state   <= LD_IDLE;
                        load_valid <= 1'b1;
                    end
                end
                default: ld_state <= LD_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // store, AW then W then B
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_state   <= ST_IDLE;
            store_done <= 1'b0;
        end else begin
            store_done <= 1'b0;
            case (st_state)
                ST_IDLE: if (store_start) st_state <= ST_AW;
                ST_AW:   if (dmem_wr_s.awready) st_state <= ST_W;
                ST_W:    if (dmem_wr_s.wready) st_state <= ST_B;
                ST_B: begin
                    if (dmem_wr_s.bvalid) begin
                        st_state   <= ST_IDLE;
                        store_done <= 1'b1;
                    end
                end
                default: st_state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_start || store_start) begin
            mem_addr <= `CPU_MEM_BASE + {{(`CPU_ADDR_W-`CPU_PC_W){1'b0}}, data_addr};
        end
        if (store_start) st_data <= operands.rt_data;
        if (ld_state == LD_DATA && dmem_rd_s.rvalid) load_data <= dmem_rd_s.rdata;
    end

    // valids and readies come straight from the state
    assign dmem_rd_m = '{arvalid: (ld_state == LD_ADDR), araddr: mem_addr,
                         rready: (ld_state == LD_DATA)};

    assign dmem_wr_m = '{awvalid: (st_state == ST_AW), awaddr: mem_addr,
                         wvalid: (st_state == ST_W), wdata: st_data,
                         bready: (st_state == ST_B)};

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    output logic      io_stall,
    output axi_rd_m_t imem_m,
    input  axi_rd_s_t imem_s,
    output axi_rd_m_t dmem_rd_m,
    input  axi_rd_s_t dmem_rd_s,
    output axi_wr_m_t dmem_wr_m,
    input  axi_wr_s_t dmem_wr_s
);

    // controller to units
    logic fetch_start;
    logic decode_en;
    logic exec_en;
    logic wb_en;
    logic load_start;
    logic store_start;

    // units back to controller
    logic inst_valid;
    logic load_valid;
    logic store_done;

    // datapath
    inst_t                  inst;
    operands_t              operands;
    logic [`CPU_DATA_W-1:0] alu_result;
    logic [`CPU_DATA_W-1:0] load_data;
    logic [`CPU_PC_W-1:0]   data_addr;
    logic                   branch_taken;

    cpu_control u_control (
        .clk(clk), .rst_n(rst_n), .inst(inst),
        .inst_valid(inst_valid), .load_valid(load_valid), .store_done(store_done),
        .fetch_start(fetch_start), .decode_en(decode_en), .exec_en(exec_en),
        .wb_en(wb_en), .load_start(load_start), .store_start(store_start),
        .io_stall(io_stall)
    );

    fetch_unit u_fetch (
        .clk(clk), .rst_n(rst_n), .fetch_start(fetch_start), .exec_en(exec_en),
        .branch_taken(branch_taken), .imem_m(imem_m), .imem_s(imem_s),
        .inst(inst), .inst_valid(inst_valid)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n), .inst(inst), .decode_en(decode_en),
        .wb_en(wb_en), .load_valid(load_valid), .alu_result(alu_result),
        .load_data(load_data), .operands(operands)
    );

    execute_unit u_execute (
        .clk(clk), .rst_n(rst_n), .exec_en(exec_en), .inst(inst),
        .operands(operands), .alu_result(alu_result), .data_addr(data_addr),
        .branch_taken(branch_taken)
    );

    mem_unit u_mem (
        .clk(clk), .rst_n(rst_n), .load_start(load_start), .store_start(store_start),
        .data_addr(data_addr), .operands(operands),
        .dmem_rd_m(dmem_rd_m), .dmem_rd_s(dmem_rd_s),
        .dmem_wr_m(dmem_wr_m), .dmem_wr_s(dmem_wr_s),
        .load_data(load_data), .load_valid(load_valid), .store_done(store_done)
    );

endmodule

`default_nettype wire

//--- testbench/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module tb_cpu_top
    import cpu_pkg::*;
();

    localparam int MEM_WORDS    = 2048;
    localparam int NUM_INSTS    = 400;
    localparam int INST_TIMEOUT = 200;    // cycles allowed per instruction

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      io_stall;
    axi_rd_m_t imem_m;
    axi_rd_s_t imem_s = '0;
    axi_rd_m_t dmem_rd_m;
    axi_rd_s_t dmem_rd_s = '0;
    axi_wr_m_t dmem_wr_m;
    axi_wr_s_t dmem_wr_s = '0;

    logic        [15:0] imem     [MEM_WORDS];
    logic        [15:0] dmem     [MEM_WORDS];    // slave side copy written by stores
    logic        [15:0] ref_dmem [MEM_WORDS];    // model copy
    logic signed [15:0] ref_regs [16];
    logic        [11:0] ref_pc = '0;
    inst_t              cur_inst;

    int errors     = 0;
    int retired    = 0;
    int fetched    = 0;
    int loads      = 0;
    int stores     = 0;
    int ref_loads  = 0;
    int ref_stores = 0;

    // slave model state
    int          i_wait = 0;
    logic        i_busy = 1'b0;
    logic [10:0] i_idx  = '0;
    int          d_wait = 0;
    logic        d_busy = 1'b0;
    logic [10:0] d_idx  = '0;
    int          w_wait = 0;
    logic [1:0]  w_phase = 2'd0;    // address, data, response
    logic [10:0] w_idx  = '0;

    // monitor state from the previous edge
    logic      stall_q = 1'b1;
    logic      i_open  = 1'b0;
    logic      d_open  = 1'b0;
    logic      aw_open = 1'b0;
    logic      w_open  = 1'b0;
    axi_rd_m_t imem_q  = '0;
    axi_rd_s_t imem_sq = '0;
    axi_rd_m_t drd_q   = '0;
    axi_rd_s_t drd_sq  = '0;
    axi_wr_m_t dwr_q   = '0;
    axi_wr_s_t dwr_sq  = '0;

    always #4 clk = ~clk;

    cpu_top u_dut (
        .clk(clk), .rst_n(rst_n), .io_stall(io_stall),
        .imem_m(imem_m), .imem_s(imem_s),
        .dmem_rd_m(dmem_rd_m), .dmem_rd_s(dmem_rd_s),
        .dmem_wr_m(dmem_wr_m), .dmem_wr_s(dmem_wr_s)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("ERROR %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic expect_reset_outputs();
        check_value("valid and ready outputs", 32'({imem_m.arvalid, imem_m.rready,
                    dmem_rd_m.arvalid, dmem_rd_m.rready, dmem_wr_m.awvalid,
                    dmem_wr_m.wvalid, dmem_wr_m.bready}), 32'd0);
        check_value("done pulses", 32'({u_dut.inst_valid, u_dut.load_valid,
                    u_dut.store_done}), 32'd0);
        check_value("io_stall", 32'(io_stall), 32'd1);
    endtask

    // mostly the six defined opcodes
    function automatic logic [15:0] random_inst();
        logic [15:0] word;
        word = 16'($urandom);
        if ($urandom_range(0, 15) == 0) begin
            word[15:13] = {2'b11, 1'($urandom)};
        end else begin
            word[15:13] = 3'($urandom_range(0, 5));
        end
        if (word[15:13] == 3'b101) word[0] = 1'b0;                          // even target
        if (word[15:13] == 3'b100 && word[4:0] == 5'h1f) word[4:0] = 5'h00; // no self loop
        return word;
    endfunction

    function automatic int signed_imm(inst_t ins);
        int imm;
        imm = int'({ins.rd, ins.func});
        if (imm > 15) begin
            imm = imm - 32;
        end
        return imm;
    endfunction

    function automatic int data_byte_addr(inst_t ins);
        return ((int'(ref_regs[ins.rs]) + signed_imm(ins)) * 2) & 32'h0fff;
    endfunction

    // ------------------------------------------------------------------
    // instruction-set model stepped once per retired instruction
    // ------------------------------------------------------------------
    task automatic step_model();
        inst_t       ins;
        int          rs_v;
        int          rt_v;
        logic [10:0] idx;
        logic [11:0] next_pc;
        ins     = inst_t'(imem[ref_pc[11:1]]);
        rs_v    = int'(ref_regs[ins.rs]);
        rt_v    = int'(ref_regs[ins.rt]);
        idx     = 11'(data_byte_addr(ins) / 2);
        next_pc = ref_pc + 12'd2;
        case (ins.op)
            OP_ADDSUB: ref_regs[ins.rd] = ins.func ? 16'(rs_v - rt_v) : 16'(rs_v + rt_v);
            OP_SLTMUL: ref_regs[ins.rd] = ins.func ? 16'(rs_v * rt_v)
                                                   : ((rs_v < rt_v) ? 16'd1 : 16'd0);
            OP_LOAD: begin
                ref_regs[ins.rt] = ref_dmem[idx];
                ref_loads++;
            end
            OP_STORE: begin
                ref_dmem[idx] = ref_regs[ins.rt];
                ref_stores++;
            end
            OP_BEQ:    if (rs_v == rt_v) next_pc = 12'(int'(ref_pc) + 2 + 2 * signed_imm(ins));
            OP_JUMP:   next_pc = ins[11:0];
            default:   ;    // 110 and 111 just step
        endcase
        ref_pc = next_pc;
    endtask

    // ------------------------------------------------------------------
    // slave models driven on the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            imem_s <= '0;
            i_busy <= 1'b0;
        end else if (imem_s.arready) begin
            imem_s.arready <= 1'b0;    // address taken at the last edge
            i_busy         <= 1'b1;
            i_wait         <= $urandom_range(0, 3);
        end else if (imem_s.rvalid) begin
            imem_s.rvalid <= 1'b0;
            i_busy        <= 1'b0;
            i_wait        <= $urandom_range(0, 3);
        end else if (i_busy) begin
            if (i_wait > 0) begin
                i_wait <= i_wait - 1;
            end else if (imem_m.rready) begin
                imem_s.rvalid <= 1'b1;
                imem_s.rdata  <= imem[i_idx];
            end
        end else if (imem_m.arvalid) begin
            if (i_wait > 0) begin
                i_wait <= i_wait - 1;
            end else begin
                imem_s.arready <= 1'b1;
                i_idx          <= imem_m.araddr[11:1];
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            dmem_rd_s <= '0;
            d_busy    <= 1'b0;
        end else if (dmem_rd_s.arready) begin
            dmem_rd_s.arready <= 1'b0;
            d_busy            <= 1'b1;
            d_wait            <= $urandom_range(0, 3);
        end else if (dmem_rd_s.rvalid) begin
            dmem_rd_s.rvalid <= 1'b0;
            d_busy           <= 1'b0;
            d_wait           <= $urandom_range(0, 3);
        end else if (d_busy) begin
            if (d_wait > 0) begin
                d_wait <= d_wait - 1;
            end else if (dmem_rd_m.rready) begin
                dmem_rd_s.rvalid <= 1'b1;
                dmem_rd_s.rdata  <= dmem[d_idx];
            end
        end else if (dmem_rd_m.arvalid) begin
            if (d_wait > 0) begin
                d_wait <= d_wait - 1;
            end else begin
                dmem_rd_s.arready <= 1'b1;
                d_idx             <= dmem_rd_m.araddr[11:1];
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            dmem_wr_s <= '0;
            w_phase   <= 2'd0;
        end else if (dmem_wr_s.awready) begin
            dmem_wr_s.awready <= 1'b0;
            w_phase           <= 2'd1;
            w_wait            <= $urandom_range(0, 3);
        end else if (dmem_wr_s.wready) begin
            dmem_wr_s.wready <= 1'b0;
            w_phase          <= 2'd2;
            w_wait           <= $urandom_range(0, 3);
        end else if (dmem_wr_s.bvalid) begin
            dmem_wr_s.bvalid <= 1'b0;
            w_phase          <= 2'd0;
            w_wait           <= $urandom_range(0, 3);
        end else if ((w_phase == 2'd0 && dmem_wr_m.awvalid) ||
                     (w_phase == 2'd1 && dmem_wr_m.wvalid) ||
                     (w_phase == 2'd2 && dmem_wr_m.bready)) begin
            if (w_wait > 0) begin
                w_wait <= w_wait - 1;
            end else if (w_phase == 2'd0) begin
                dmem_wr_s.awready <= 1'b1;
                w_idx             <= dmem_wr_m.awaddr[11:1];
            end else if (w_phase == 2'd1) begin
                dmem_wr_s.wready <= 1'b1;
                dmem[w_idx]      <= dmem_wr_m.wdata;
            end else begin
                dmem_wr_s.bvalid <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // monitor sampling the settled values at each rising edge
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (!io_stall) begin
                if (!stall_q) begin
                    errors++;
                    $display("io_stall stayed low for more than one cycle at %0t", $time);
                end
                retired++;
                check_value("instruction count", fetched, retired);
                step_model();
                check_value("load count", loads, ref_loads);
                check_value("store count", stores, ref_stores);
            end
            cur_inst = inst_t'(imem[ref_pc[11:1]]);

            if (imem_m.arvalid && imem_s.arready) begin
                if (i_open) begin
                    errors++;
                    $display("second instruction address accepted at %0t", $time);
                end
                i_open = 1'b1;
                check_value("imem_m.araddr", imem_m.araddr, `CPU_MEM_BASE + 32'(ref_pc));
            end
            if (imem_m.rready && imem_s.rvalid) begin
                i_open = 1'b0;
                fetched++;
            end

            if (dmem_rd_m.arvalid && dmem_rd_s.arready) begin
                if (cur_inst.op != OP_LOAD || d_open) begin
                    errors++;
                    $display("unexpected data read at %0t", $time);
                end
                d_open = 1'b1;
                check_value("dmem_rd_m.araddr", dmem_rd_m.araddr,
                            `CPU_MEM_BASE + 32'(data_byte_addr(cur_inst)));
            end
            if (dmem_rd_m.rready && dmem_rd_s.rvalid) begin
                d_open = 1'b0;
                loads++;
            end

            // store order is AW then W then B with each accepted once
            if (dmem_wr_m.awvalid && dmem_wr_s.awready) begin
                if (cur_inst.op != OP_STORE || aw_open) begin
                    errors++;
                    $display("unexpected write address at %0t", $time);
                end
                aw_open = 1'b1;
                check_value("dmem_wr_m.awaddr", dmem_wr_m.awaddr,
                            `CPU_MEM_BASE + 32'(data_byte_addr(cur_inst)));
            end
            if (dmem_wr_m.wvalid && dmem_wr_s.wready) begin
                if (!aw_open || w_open) begin
                    errors++;
                    $display("write data out of order at %0t", $time);
                end
                w_open = 1'b1;
                check_value("dmem_wr_m.wdata", {16'd0, dmem_wr_m.wdata},
                            {16'd0, ref_regs[cur_inst.rt]});
            end
            if (dmem_wr_m.bready && dmem_wr_s.bvalid) begin
                if (!w_open) begin
                    errors++;
                    $display("write response before write data at %0t", $time);
                end
                aw_open = 1'b0;
                w_open  = 1'b0;
                stores++;
            end

            // a stalled valid holds with its payload
            if (imem_q.arvalid && !imem_sq.arready) begin
                check_value("imem_m.arvalid", 32'(imem_m.arvalid), 32'd1);
                check_value("imem_m.araddr", imem_m.araddr, imem_q.araddr);
            end
            if (drd_q.arvalid && !drd_sq.arready) begin
                check_value("dmem_rd_m.arvalid", 32'(dmem_rd_m.arvalid), 32'd1);
                check_value("dmem_rd_m.araddr", dmem_rd_m.araddr, drd_q.araddr);
            end
            if (dwr_q.awvalid && !dwr_sq.awready) begin
                check_value("dmem_wr_m.awvalid", 32'(dmem_wr_m.awvalid), 32'd1);
                check_value("dmem_wr_m.awaddr", dmem_wr_m.awaddr, dwr_q.awaddr);
            end
            if (dwr_q.wvalid && !dwr_sq.wready) begin
                check_value("dmem_wr_m.wvalid", 32'(dmem_wr_m.wvalid), 32'd1);
                check_value("dmem_wr_m.wdata", 32'(dmem_wr_m.wdata), 32'(dwr_q.wdata));
            end
        end
        stall_q = io_stall;
        imem_q  = imem_m;
        imem_sq = imem_s;
        drd_q   = dmem_rd_m;
        drd_sq  = dmem_rd_s;
        dwr_q   = dmem_wr_m;
        dwr_sq  = dmem_wr_s;
    end

    initial begin
        int cycles;
        int n;
        void'($urandom(32'hc8ca));
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[11'(i)]     = random_inst();
            dmem[11'(i)]     = 16'($urandom);
            ref_dmem[11'(i)] = dmem[11'(i)];
        end
        ref_regs = '{default: '0};

        repeat (5) begin
            @(negedge clk);
            expect_reset_outputs();
        end
        rst_n <= 1'b1;
        @(negedge clk);
        expect_reset_outputs();    // first cycle out of reset

        n = 0;
        while (n < NUM_INSTS) begin
            cycles = 0;
            while (retired == n && cycles < INST_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (retired == n) begin
                errors++;
                $display("timeout waiting for instruction %0d to retire", n + 1);
                n = NUM_INSTS;
            end else begin
                n = retired;
            end
        end

        $display("errors %0d  retired %0d  fetched %0d  loads %0d  stores %0d",
                 errors, retired, fetched, loads, stores);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu_top.f
+incdir+include
verilog/cpu_pkg.sv
verilog/cpu_control.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/mem_unit.sv
verilog/cpu_top.sv
testbench/tb_cpu_top.sv

//--- Makefile
# Verilator build and run for the cpu_top testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= cpu_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/1ps
PASS_MSG  ?= TEST OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
